// ==== Makefile ====
TOP = tb_out_buf_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== files.f ====
verilog/buf_mem_pkg.sv
verilog/conv_acc_pkg.sv
verilog/sp_ram_if.sv
verilog/out_buf_sram.sv
verilog/out_buf_wrapper.sv
verilog/psum_accumulator.sv
verilog/out_buf_top.sv
verif/tb_out_buf_top.sv

// ==== verif/out_buf_input.txt ====
# Columns: W addr data name | F name | A ADD/MAX addr data name
# E cycles addr data name | R addr expected name  (addr, data and expected in hex)
W 10 00000005 host_wr_10
W 11 fffffff0 host_wr_11
W 12 00000064 host_wr_12
W 13 fffffff6 host_wr_13
W 14 00000010 host_wr_14
W 20 12345678 host_wr_20
W 21 0000abcd host_wr_21
R 10 00000005 wr_then_rd_10
R 21 0000abcd wr_then_rd_21
F handover_1
A ADD 10 00000003 add_10_first
A ADD 10 00000004 add_10_second
A ADD 11 00000020 add_11_wrap
A MAX 12 ffffff00 max_12_neg_item
A MAX 13 fffffffe max_13_both_neg
A MAX 14 00000200 max_14_larger
E 3 20 deadbeef disabled_wr_strobe
R 10 0000000c add_accumulates
R 11 00000010 add_wraps
R 12 00000064 max_keeps_pos
R 13 fffffffe max_signed_neg
R 14 00000200 max_takes_item
R 20 12345678 disabled_wr_kept
F handover_2
A ADD 10 00000001 add_after_reclaim
A MAX 12 00000065 max_after_reclaim
R 10 0000000d rehand_add
R 12 00000065 rehand_max
R 11 00000010 rehand_kept_11
R 21 0000abcd untouched_21

// ==== verif/tb_out_buf_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_out_buf_top
  import buf_mem_pkg::*;
  import conv_acc_pkg::*;
();

  localparam int READ_TIMEOUT = 8;  // Cycles allowed for rvalid_o to rise

  logic                  clk;
  logic                  rst;
  logic                  enb_i;
  logic                  host_ar_i;
  logic                  host_aw_i;
  logic                  host_fin_i;
  logic                  host_cs_i;
  logic                  host_oe_i;
  logic [BUF_ADDR_W-1:0] host_addr_i;
  logic [BUF_DATA_W-1:0] host_wdata_i;
  logic                  rvalid_o;
  logic [BUF_DATA_W-1:0] rdata_o;
  logic                  acc_valid_i;
  acc_op_e               acc_op_i;
  logic [BUF_ADDR_W-1:0] acc_addr_i;
  logic [BUF_DATA_W-1:0] acc_data_i;

  buf_owner_e phase;  // Owner the testbench last asked for
  int         tests;
  int         errors;

  out_buf_top u_out_buf_top (
    .clk          (clk),
    .rst          (rst),
    .enb_i        (enb_i),
    .host_ar_i    (host_ar_i),
    .host_aw_i    (host_aw_i),
    .host_fin_i   (host_fin_i),
    .host_cs_i    (host_cs_i),
    .host_oe_i    (host_oe_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o),
    .acc_valid_i  (acc_valid_i),
    .acc_op_i     (acc_op_i),
    .acc_addr_i   (acc_addr_i),
    .acc_data_i   (acc_data_i)
  );

  always #20 clk = ~clk;

  // ----------------------------------------
  // Host and engine drivers
  // ----------------------------------------

  task automatic check_value(input logic [8*32-1:0] test_name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error: test %0s %0s expected %h actual %h", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic pulse_strobe(input logic ar, input logic aw, input logic fin);
    @(negedge clk);
    host_ar_i  = ar;
    host_aw_i  = aw;
    host_fin_i = fin;
    @(negedge clk);
    host_ar_i  = 1'b0;
    host_aw_i  = 1'b0;
    host_fin_i = 1'b0;
  endtask

  // A host phase can only be left through a finish strobe
  task automatic enter_phase(input buf_owner_e target);
    if (phase != target) begin
      if (phase == OWN_HOST_RD || phase == OWN_HOST_WR) pulse_strobe(1'b0, 1'b0, 1'b1);
      if (target == OWN_HOST_RD) pulse_strobe(1'b1, 1'b0, 1'b0);
      else pulse_strobe(1'b0, 1'b1, 1'b0);
      phase = target;
    end
  endtask

  task automatic host_write(input logic [BUF_ADDR_W-1:0] addr, input logic [31:0] data);
    enter_phase(OWN_HOST_WR);
    @(negedge clk);
    host_cs_i    = 1'b1;
    host_addr_i  = addr;
    host_wdata_i = data;
    @(negedge clk);
    host_cs_i = 1'b0;
  endtask

  task automatic host_read(input logic [BUF_ADDR_W-1:0] addr, input logic [31:0] expected,
                           input logic [8*32-1:0] test_name);
    int waited;
    int errs_before;
    errs_before = errors;
    enter_phase(OWN_HOST_RD);
    @(negedge clk);
    host_cs_i   = 1'b1;
    host_oe_i   = 1'b1;
    host_addr_i = addr;
    @(negedge clk);
    host_cs_i = 1'b0;
    host_oe_i = 1'b0;
    waited    = 0;
    while (!rvalid_o && waited < READ_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!rvalid_o) begin
      $display("Timed out waiting for rvalid_o in test %0s", test_name);
      errors++;
    end else begin
      // Read data belongs in the cycle right after the read
      check_value(test_name, "rvalid extra cycles", 32'd0, waited);
      check_value(test_name, "rdata", expected, rdata_o);
      @(negedge clk);
      check_value(test_name, "rvalid one cycle later", 32'd0, {31'd0, rvalid_o});
      check_value(test_name, "rdata one cycle later", 32'd0, rdata_o);
    end
    tests++;
    if (errors == errs_before) $display("%0s: ok", test_name);
    else $display("%0s: FAIL", test_name);
  endtask

  task automatic acc_item(input acc_op_e op, input logic [BUF_ADDR_W-1:0] addr,
                          input logic [31:0] data);
    @(negedge clk);
    acc_valid_i = 1'b1;
    acc_op_i    = op;
    acc_addr_i  = addr;
    acc_data_i  = data;
    @(negedge clk);
    acc_valid_i = 1'b0;
    @(negedge clk);  // Spacing cycle so the write-back finishes alone
  endtask

  // Write strobe with enb_i low, then a write attempt once enb_i is back
  task automatic disabled_write(input int cycles, input logic [BUF_ADDR_W-1:0] addr,
                                input logic [31:0] data);
    @(negedge clk);
    enb_i     = 1'b0;
    host_aw_i = 1'b1;
    @(negedge clk);
    host_aw_i = 1'b0;
    repeat (cycles - 1) @(negedge clk);
    enb_i        = 1'b1;
    host_cs_i    = 1'b1;
    host_addr_i  = addr;
    host_wdata_i = data;
    @(negedge clk);
    host_cs_i = 1'b0;
  endtask

  // ----------------------------------------
  // Command interpreter
  // ----------------------------------------

  task automatic run_line(input logic [8*128-1:0] text);
    logic [7:0]            cmd;
    logic [23:0]           op_s;
    logic [BUF_ADDR_W-1:0] addr_v;
    logic [31:0]           data_v;
    logic [8*32-1:0]       name_s;
    int                    n;
    int                    cycles;
    n = $sscanf(text, "%s", cmd);
    if (n >= 1 && cmd != "#") begin
      case (cmd)
        "W": n = $sscanf(text, "%s %h %h %s", cmd, addr_v, data_v, name_s) - 4;
        "F": n = $sscanf(text, "%s %s", cmd, name_s) - 2;
        "A": n = $sscanf(text, "%s %s %h %h %s", cmd, op_s, addr_v, data_v, name_s) - 5;
        "E": n = $sscanf(text, "%s %d %h %h %s", cmd, cycles, addr_v, data_v, name_s) - 5;
        "R": n = $sscanf(text, "%s %h %h %s", cmd, addr_v, data_v, name_s) - 4;
        default: n = -1;
      endcase
      if (n < 0) begin
        $display("Could not parse command line: %0s", text);
        errors++;
      end else begin
        case (cmd)
          "W": host_write(addr_v, data_v);
          "F": begin
            pulse_strobe(1'b0, 1'b0, 1'b1);
            phase = OWN_ENGINE;
          end
          "A": acc_item((op_s == "MAX") ? ACC_MAX : ACC_ADD, addr_v, data_v);
          "E": disabled_write(cycles, addr_v, data_v);
          default: host_read(addr_v, data_v, name_s);
        endcase
      end
    end
  endtask

  initial begin
    int              fd;
    int              n;
    logic [8*128-1:0] line_buf;
    clk          = 1'b0;
    rst          = 1'b1;
    enb_i        = 1'b1;
    host_ar_i    = 1'b0;
    host_aw_i    = 1'b0;
    host_fin_i   = 1'b0;
    host_cs_i    = 1'b0;
    host_oe_i    = 1'b0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    acc_valid_i  = 1'b0;
    acc_op_i     = ACC_ADD;
    acc_addr_i   = '0;
    acc_data_i   = '0;
    phase        = OWN_IDLE;
    tests        = 0;
    errors       = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    fd = $fopen("verif/out_buf_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the command file verif/out_buf_input.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line_buf = '0;
        n = $fgets(line_buf, fd);
        if (n > 0) run_line(line_buf);
      end
      $fclose(fd);
    end

    repeat (2) @(negedge clk);
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : tb_out_buf_top

`default_nettype wire

// ==== verilog/buf_mem_pkg.sv ====
`default_nettype none

package buf_mem_pkg;

  // ----------------------------------------
  // Output buffer geometry
  // ----------------------------------------

  // Word address into the buffer SRAM
  localparam int BUF_ADDR_W = 8;

  // One partial sum per word
  localparam int BUF_DATA_W = 32;

  // The address space is fully populated
  localparam int BUF_DEPTH = 1 << BUF_ADDR_W;

endpackage : buf_mem_pkg

`default_nettype wire

// ==== verilog/conv_acc_pkg.sv ====
`default_nettype none

package conv_acc_pkg;

  // ----------------------------------------
  // Owner of the output buffer
  // ----------------------------------------

  typedef enum logic [1:0] {
    OWN_IDLE    = 2'h0,  // Nobody may touch the SRAM
    OWN_ENGINE  = 2'h1,  // Accumulator does read-modify-write
    OWN_HOST_RD = 2'h2,
    OWN_HOST_WR = 2'h3
  } buf_owner_e;

  // ----------------------------------------
  // Accumulate opcodes
  // ----------------------------------------

  // ADD wraps modulo the word width, MAX compares signed
  typedef enum logic {
    ACC_ADD = 1'b0,
    ACC_MAX = 1'b1
  } acc_op_e;

endpackage : conv_acc_pkg

`default_nettype wire

// ==== verilog/out_buf_sram.sv ====
`timescale 1ns/100ps
`default_nettype none

module out_buf_sram
  import buf_mem_pkg::*;
(
  input  wire logic clk,
  sp_ram_if.memory  mem
);

  logic [BUF_DATA_W-1:0] mem_array [BUF_DEPTH];
  logic [BUF_DATA_W-1:0] rdata_q;

  // Write takes priority, a read only happens with w_req low
  always_ff @(posedge clk) begin
    if (mem.cs && mem.w_req) begin
      mem_array[mem.addr] <= mem.w_data;
    end else if (mem.cs && mem.oe) begin
      rdata_q <= mem_array[mem.addr];  // Holds its value between reads
    end
  end

  assign mem.r_data = rdata_q;

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // A selected SRAM must always see a resolved address from the wrapper
  a_addr_known: assert property (
    @(posedge clk) mem.cs |-> !$isunknown(mem.addr)
  );

endmodule : out_buf_sram

`default_nettype wire

// ==== verilog/out_buf_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module out_buf_top
  import buf_mem_pkg::*;
  import conv_acc_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  enb_i,
  input  wire logic                  host_ar_i,
  input  wire logic                  host_aw_i,
  input  wire logic                  host_fin_i,
  input  wire logic                  host_cs_i,
  input  wire logic                  host_oe_i,
  input  wire logic [BUF_ADDR_W-1:0] host_addr_i,
  input  wire logic [BUF_DATA_W-1:0] host_wdata_i,
  output      logic                  rvalid_o,
  output      logic [BUF_DATA_W-1:0] rdata_o,
  input  wire logic                  acc_valid_i,
  input  wire acc_op_e               acc_op_i,
  input  wire logic [BUF_ADDR_W-1:0] acc_addr_i,
  input  wire logic [BUF_DATA_W-1:0] acc_data_i
);

  sp_ram_if eng_bus ();  // Accumulator to wrapper
  sp_ram_if mem_bus ();  // Wrapper to SRAM

  out_buf_wrapper u_out_buf_wrapper (
    .clk          (clk),
    .rst          (rst),
    .enb_i        (enb_i),
    .host_ar_i    (host_ar_i),
    .host_aw_i    (host_aw_i),
    .host_fin_i   (host_fin_i),
    .host_cs_i    (host_cs_i),
    .host_oe_i    (host_oe_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o),
    .eng_bus      (eng_bus.memory),
    .mem_bus      (mem_bus.master)
  );

  psum_accumulator u_psum_accumulator (
    .clk         (clk),
    .rst         (rst),
    .acc_valid_i (acc_valid_i),
    .acc_op_i    (acc_op_i),
    .acc_addr_i  (acc_addr_i),
    .acc_data_i  (acc_data_i),
    .bus         (eng_bus.master)
  );

  out_buf_sram u_out_buf_sram (
    .clk (clk),
    .mem (mem_bus.memory)
  );

endmodule : out_buf_top

`default_nettype wire

// ==== verilog/out_buf_wrapper.sv ====
`timescale 1ns/100ps
`default_nettype none

module out_buf_wrapper
  import buf_mem_pkg::*;
  import conv_acc_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  enb_i,
  input  wire logic                  host_ar_i,
  input  wire logic                  host_aw_i,
  input  wire logic                  host_fin_i,
  input  wire logic                  host_cs_i,
  input  wire logic                  host_oe_i,
  input  wire logic [BUF_ADDR_W-1:0] host_addr_i,
  input  wire logic [BUF_DATA_W-1:0] host_wdata_i,
  output      logic                  rvalid_o,
  output      logic [BUF_DATA_W-1:0] rdata_o,
  sp_ram_if.memory                   eng_bus,
  sp_ram_if.master                   mem_bus
);

  buf_owner_e state_q;
  buf_owner_e state_d;
  logic       host_rd_issue;
  logic       eng_rd_issue;
  logic       host_rd_q;  // Last read came from the host
  logic       eng_rd_q;   // Last read came from the accumulator

  // ----------------------------------------
  // Owner FSM
  // ----------------------------------------

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= OWN_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      OWN_IDLE, OWN_ENGINE: begin
        // Read phase wins when both strobes arrive together
        if (host_ar_i && enb_i) begin
          state_d = OWN_HOST_RD;
        end else if (host_aw_i && enb_i) begin
          state_d = OWN_HOST_WR;
        end
      end
      OWN_HOST_RD, OWN_HOST_WR: begin
        if (host_fin_i && enb_i) state_d = OWN_ENGINE;  // Hand buffer to engine
      end
      default: state_d = OWN_IDLE;
    endcase
  end

  // ----------------------------------------
  // SRAM port steering
  // ----------------------------------------

  always_comb begin
    mem_bus.cs     = 1'b0;
    mem_bus.oe     = 1'b0;
    mem_bus.addr   = '0;
    mem_bus.w_req  = 1'b0;
    mem_bus.w_data = '0;
    case (state_q)
      OWN_ENGINE: begin
        mem_bus.cs     = eng_bus.cs;
        mem_bus.oe     = eng_bus.oe;
        mem_bus.addr   = eng_bus.addr;
        mem_bus.w_req  = eng_bus.w_req;
        mem_bus.w_data = eng_bus.w_data;
      end
      OWN_HOST_RD: begin
        mem_bus.cs   = host_cs_i && enb_i;
        mem_bus.oe   = host_oe_i;
        mem_bus.addr = host_addr_i;  // Writes stay off in this phase
      end
      OWN_HOST_WR: begin
        mem_bus.cs     = host_cs_i && enb_i;
        mem_bus.addr   = host_addr_i;
        mem_bus.w_req  = 1'b1;
        mem_bus.w_data = host_wdata_i;
      end
      default: ;
    endcase
  end

  // Read data returns one cycle late, so route it by who asked
  assign host_rd_issue = (state_q == OWN_HOST_RD) && host_cs_i && host_oe_i && enb_i;
  assign eng_rd_issue  = (state_q == OWN_ENGINE) && eng_bus.cs && eng_bus.oe
                         && !eng_bus.w_req;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      host_rd_q <= 1'b0;
      eng_rd_q  <= 1'b0;
    end else begin
      host_rd_q <= host_rd_issue;
      eng_rd_q  <= eng_rd_issue;
    end
  end

  assign rvalid_o       = host_rd_q;
  assign rdata_o        = host_rd_q ? mem_bus.r_data : '0;
  assign eng_bus.r_data = eng_rd_q ? mem_bus.r_data : '0;

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // Items are only allowed while the engine owns the buffer
  a_eng_owns: assert property (
    @(posedge clk) disable iff (rst) eng_bus.cs |-> state_q == OWN_ENGINE
  );

  // Host read data must match an actual host read on the SRAM port
  a_rvalid_src: assert property (
    @(posedge clk) disable iff (rst)
    rvalid_o |-> $past(mem_bus.cs && mem_bus.oe && !mem_bus.w_req
                       && state_q == OWN_HOST_RD)
  );

  // A reclaim in the middle of a read-modify-write would drop the update
  a_no_reclaim_mid_item: assert property (
    @(posedge clk) disable iff (rst)
    (state_q == OWN_ENGINE && enb_i && (host_ar_i || host_aw_i)) |-> !eng_bus.cs
  );

endmodule : out_buf_wrapper

`default_nettype wire

// ==== verilog/psum_accumulator.sv ====
`timescale 1ns/100ps
`default_nettype none

module psum_accumulator
  import buf_mem_pkg::*;
  import conv_acc_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  acc_valid_i,
  input  wire acc_op_e               acc_op_i,
  input  wire logic [BUF_ADDR_W-1:0] acc_addr_i,
  input  wire logic [BUF_DATA_W-1:0] acc_data_i,
  sp_ram_if.master                   bus
);

  logic                  s1_valid_q;
  acc_op_e               s1_op_q;
  logic [BUF_ADDR_W-1:0] s1_addr_q;
  logic [BUF_DATA_W-1:0] s1_data_q;
  logic [BUF_DATA_W-1:0] result;

  // ----------------------------------------
  // Stage one: read issue
  // ----------------------------------------

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= acc_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (acc_valid_i) begin
      s1_op_q   <= acc_op_i;
      s1_addr_q <= acc_addr_i;
      s1_data_q <= acc_data_i;
    end
  end

  // ----------------------------------------
  // Stage two: combine and write back
  // ----------------------------------------

  always_comb begin
    case (s1_op_q)
      ACC_MAX: begin
        result = ($signed(bus.r_data) > $signed(s1_data_q)) ? bus.r_data : s1_data_q;
      end
      default: result = bus.r_data + s1_data_q;  // Wraps on overflow
    endcase
  end

  // The write of the older item owns the port in its cycle
  always_comb begin
    bus.cs     = acc_valid_i || s1_valid_q;
    bus.oe     = acc_valid_i && !s1_valid_q;
    bus.w_req  = s1_valid_q;
    bus.addr   = s1_valid_q ? s1_addr_q : acc_addr_i;
    bus.w_data = s1_valid_q ? result : '0;
  end

  // Back-to-back items would collide with the write-back
  a_item_spacing: assert property (
    @(posedge clk) disable iff (rst) acc_valid_i |=> !acc_valid_i
  );

endmodule : psum_accumulator

`default_nettype wire

// ==== verilog/sp_ram_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface sp_ram_if
  import buf_mem_pkg::*;
();

  logic                  cs;
  logic                  oe;
  logic [BUF_ADDR_W-1:0] addr;
  logic                  w_req;   // High writes w_data at the edge
  logic [BUF_DATA_W-1:0] w_data;
  logic [BUF_DATA_W-1:0] r_data;  // Valid the cycle after a read

  modport master (
    output cs, oe, addr, w_req, w_data,
    input  r_data
  );

  modport memory (
    input  cs, oe, addr, w_req, w_data,
    output r_data
  );

endinterface : sp_ram_if

`default_nettype wire
